// File: common/riscv_pkg.sv
package riscv_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes and encodings
    ////////////////////////////////////////////////////////////
    localparam int XLEN    = 32;
    localparam int IMEM_AW = 12;  // Byte address into instruction memory
    localparam int DMEM_AW = 10;  // Word address into data RAM

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;  // Only EBREAK here

    localparam logic [31:0] NOP_INSN = 32'h0000_0013;  // ADDI x0, x0, 0

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASSB  // LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    ////////////////////////////////////////////////////////////
    // Pipeline and port structs
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        alu_op_e alu_op;
        logic    src_imm;    // B operand is the immediate
        logic    src_pc;     // A operand is the PC
        logic    mem_we;
        logic    mem_re;
        logic    reg_we;
        wb_sel_e wb_sel;
        logic    is_branch;
        logic    br_ne;      // BNE rather than BEQ
        logic    is_jal;
        logic    is_halt;
        logic    valid;      // Counts as retired
    } ctrl_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] alu_res;
        logic [XLEN-1:0] store_val;
        logic [4:0]      rd;
        logic [XLEN-1:0] pc4;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t           ctrl;
        logic [XLEN-1:0] wb_val;
        logic [4:0]      rd;
    } mem_wb_t;

    typedef struct packed {
        logic [DMEM_AW-1:0] addr;
        logic [XLEN-1:0]    wdata;
        logic               we;
    } dmem_req_t;

    typedef struct packed {
        logic [4:0] ra1;
        logic [4:0] ra2;
    } rf_rd_t;

    typedef struct packed {
        logic            we;
        logic [4:0]      wa;
        logic [XLEN-1:0] wd;
    } rf_wr_t;

endpackage

// File: core/alu.sv
`timescale 1ns/100ps

module alu import riscv_pkg::*; (
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic            br_ne,
    output logic [XLEN-1:0] res,
    output logic            take
);

    logic lt;

    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD:   res = a + b;
            ALU_SUB:   res = a - b;
            ALU_AND:   res = a & b;
            ALU_OR:    res = a | b;
            ALU_XOR:   res = a ^ b;
            ALU_SLT:   res = {{(XLEN-1){1'b0}}, lt};
            ALU_PASSB: res = b;
            default:   res = a + b;
        endcase
    end

    // BEQ or BNE condition on the raw operands
    assign take = (a == b) ^ br_ne;

endmodule

// File: core/decode_ctrl.sv
`timescale 1ns/100ps

module decode_ctrl import riscv_pkg::*; (
    input  logic [31:0]     insn,
    output ctrl_t           ctrl,
    output logic [XLEN-1:0] imm,
    output rf_rd_t          rf_rd,
    output logic [4:0]      rd
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // Shared by R-type and I-type arithmetic
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opcode    = insn[6:0];
    assign funct3    = insn[14:12];
    assign funct7    = insn[31:25];
    assign rd        = insn[11:7];
    assign rf_rd.ra1 = insn[19:15];
    assign rf_rd.ra2 = insn[24:20];

    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_u = {insn[31:12], 12'b0};
    assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.wb_sel = WB_ALU;
        ctrl.valid  = 1'b1;
        imm         = imm_i;
        case (opcode)
            OP_R: begin
                ctrl.alu_op = alu_sel(funct3, funct7[5]);
                ctrl.reg_we = 1'b1;
            end
            OP_I: begin
                ctrl.alu_op  = alu_sel(funct3, 1'b0);  // No SUBI
                ctrl.src_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
            end
            OP_LUI: begin
                ctrl.alu_op  = ALU_PASSB;
                ctrl.src_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
                imm          = imm_u;
            end
            OP_LOAD: begin
                ctrl.src_imm = 1'b1;
                ctrl.mem_re  = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.wb_sel  = WB_MEM;
            end
            OP_STORE: begin
                ctrl.src_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
                imm          = imm_s;
            end
            OP_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.br_ne     = funct3[0];  // BNE is funct3 001
                imm            = imm_b;
            end
            OP_JAL: begin
                ctrl.src_pc  = 1'b1;
                ctrl.src_imm = 1'b1;
                ctrl.is_jal  = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.wb_sel  = WB_PC4;
                imm          = imm_j;
            end
            OP_SYSTEM: ctrl.is_halt = 1'b1;
            default:   ctrl.valid   = 1'b0;  // Unknown opcode
        endcase
        if (insn == NOP_INSN) begin
            ctrl.valid = 1'b0;
        end
        if (rd == 5'd0) begin
            ctrl.reg_we = 1'b0;  // x0 stays zero
        end
    end

endmodule

// File: core/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit import riscv_pkg::*; (
    input  rf_rd_t   id_rf,
    input  id_ex_t   ex,
    input  ex_mem_t  mem,
    input  mem_wb_t  wb,
    input  logic     take_branch,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b,
    output logic     stall,
    output logic     flush
);

    // Nearest producer wins, so the memory stage is checked first
    function automatic fwd_sel_e fwd_for(input logic [4:0] rs,
                                         input ex_mem_t    m,
                                         input mem_wb_t    w);
        if (rs == 5'd0) begin
            return FWD_REG;
        end else if (m.ctrl.reg_we && m.rd == rs) begin
            return FWD_MEM;
        end else if (w.ctrl.reg_we && w.rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwd_a = fwd_for(ex.rs1, mem, wb);
    assign fwd_b = fwd_for(ex.rs2, mem, wb);

    // Load result is not ready until it leaves memory
    assign stall = ex.ctrl.valid & ex.ctrl.mem_re & (ex.rd != 5'd0) &
                   ((ex.rd == id_rf.ra1) | (ex.rd == id_rf.ra2));

    assign flush = take_branch;

endmodule

// File: core/riscv_top.sv
`timescale 1ns/100ps

module riscv_top import riscv_pkg::*; (
    input  logic               CLK,
    input  logic               RSTn,
    output logic [IMEM_AW-1:0] imem_addr,
    output logic               imem_en,
    input  logic [31:0]        imem_data,
    output rf_rd_t             rf_rd,
    input  logic [XLEN-1:0]    rd1,
    input  logic [XLEN-1:0]    rd2,
    output rf_wr_t             rf_wr,
    output dmem_req_t          dmem_req,
    input  logic [XLEN-1:0]    dmem_rdata,
    output logic [31:0]        num_inst,
    output logic               halt
);

    logic [XLEN-1:0] pc;
    logic [31:0]     if_id_insn;
    logic [XLEN-1:0] if_id_pc;
    id_ex_t          id_ex;
    id_ex_t          id_ex_d;
    ex_mem_t         ex_mem;
    ex_mem_t         ex_mem_d;
    mem_wb_t         mem_wb;
    mem_wb_t         mem_wb_d;
    ctrl_t           dec_ctrl;
    logic [XLEN-1:0] dec_imm;
    logic [4:0]      dec_rd;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    logic [XLEN-1:0] fwd_a_val;
    logic [XLEN-1:0] fwd_b_val;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] mem_val;
    logic            alu_take;
    logic            take_branch;
    logic            stall;
    logic            flush;
    logic            halt_now;
    logic            halt_q;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e        sel,
                                                input logic [XLEN-1:0] reg_val,
                                                input logic [XLEN-1:0] mem_v,
                                                input logic [XLEN-1:0] wb_v);
        case (sel)
            FWD_MEM: return mem_v;
            FWD_WB:  return wb_v;
            default: return reg_val;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////
    assign imem_addr = pc[IMEM_AW-1:0];
    assign imem_en   = ~halt;

    decode_ctrl i_decode_ctrl (
        .insn  (if_id_insn),
        .ctrl  (dec_ctrl),
        .imm   (dec_imm),
        .rf_rd (rf_rd),
        .rd    (dec_rd)
    );

    assign id_ex_d = '{ctrl: dec_ctrl, pc: if_id_pc, rs1_val: rd1, rs2_val: rd2,
                       imm: dec_imm, rs1: rf_rd.ra1, rs2: rf_rd.ra2, rd: dec_rd};

    hazard_unit i_hazard_unit (
        .id_rf       (rf_rd),
        .ex          (id_ex),
        .mem         (ex_mem),
        .wb          (mem_wb),
        .take_branch (take_branch),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .stall       (stall),
        .flush       (flush)
    );

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////
    assign fwd_a_val = fwd_mux(fwd_a, id_ex.rs1_val, mem_val, mem_wb.wb_val);
    assign fwd_b_val = fwd_mux(fwd_b, id_ex.rs2_val, mem_val, mem_wb.wb_val);

    alu i_alu (
        .op    (id_ex.ctrl.alu_op),
        .a     (id_ex.ctrl.src_pc ? id_ex.pc : fwd_a_val),
        .b     (id_ex.ctrl.src_imm ? id_ex.imm : fwd_b_val),
        .br_ne (id_ex.ctrl.br_ne),
        .res   (alu_res),
        .take  (alu_take)
    );

    assign br_target   = id_ex.pc + id_ex.imm;  // Branch and JAL share the PC-relative target
    assign take_branch = id_ex.ctrl.valid &
                         (id_ex.ctrl.is_jal | (id_ex.ctrl.is_branch & alu_take));

    assign ex_mem_d = '{ctrl: id_ex.ctrl, alu_res: alu_res, store_val: fwd_b_val,
                        rd: id_ex.rd, pc4: id_ex.pc + 32'd4};

    ////////////////////////////////////////////////////////////
    // Memory and writeback
    ////////////////////////////////////////////////////////////
    assign dmem_req.addr  = ex_mem.alu_res[DMEM_AW+1:2];
    assign dmem_req.wdata = ex_mem.store_val;
    assign dmem_req.we    = ex_mem.ctrl.mem_we & ex_mem.ctrl.valid & ~halt;  // No stores past EBREAK

    always_comb begin
        case (ex_mem.ctrl.wb_sel)
            WB_MEM:  mem_val = dmem_rdata;
            WB_PC4:  mem_val = ex_mem.pc4;  // JAL link
            default: mem_val = ex_mem.alu_res;
        endcase
    end

    assign mem_wb_d = '{ctrl: ex_mem.ctrl, wb_val: mem_val, rd: ex_mem.rd};

    assign halt_now = mem_wb.ctrl.valid & mem_wb.ctrl.is_halt;
    assign halt     = halt_q | halt_now;

    assign rf_wr.we = mem_wb.ctrl.reg_we & mem_wb.ctrl.valid & ~halt_q;
    assign rf_wr.wa = mem_wb.rd;
    assign rf_wr.wd = mem_wb.wb_val;

    always_ff @(posedge CLK) begin
        if (RSTn) begin
            pc         <= '0;
            if_id_insn <= NOP_INSN;
            if_id_pc   <= '0;
            id_ex      <= '0;
            ex_mem     <= '0;
            mem_wb     <= '0;
            num_inst   <= '0;
            halt_q     <= 1'b0;
        end else begin
            if (!halt) begin
                if (flush) begin
                    pc <= br_target;  // Redirect from execute
                end else if (!stall) begin
                    pc <= pc + 32'd4;
                end
            end
            if (flush || halt) begin
                if_id_insn <= NOP_INSN;  // Squash the slot behind the branch
            end else if (!stall) begin
                if_id_insn <= imem_data;
                if_id_pc   <= pc;
            end
            id_ex  <= (flush || stall) ? id_ex_t'('0) : id_ex_d;  // Bubble
            ex_mem <= ex_mem_d;
            mem_wb <= mem_wb_d;
            if (mem_wb.ctrl.valid && !halt_q) begin
                num_inst <= num_inst + 32'd1;
            end
            if (halt_now) begin
                halt_q <= 1'b1;  // Sticky until reset
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_riscv -o sim_riscv --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_riscv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "RESULT: PASS"; then
    exit 0
fi
exit 1

// File: tests/tb_riscv.sv
`timescale 1ns/100ps

module tb_riscv import riscv_pkg::*; ();

    localparam logic [31:0] EBREAK_INSN = 32'h0010_0073;

    logic               CLK;
    logic               RSTn;
    logic [IMEM_AW-1:0] imem_addr;
    logic               imem_en;
    logic [31:0]        imem_data;
    rf_wr_t             retire;
    logic [31:0]        num_inst;
    logic               halt;

    logic [31:0] imem [0:1023];
    logic [31:0] lfsr_state;
    rf_wr_t      exp_q [$];
    rf_wr_t      got_q [$];
    int          n_insn;
    int          errors;
    int          cycles;
    int          cycle_limit;

    riscv_soc i_riscv_soc (
        .CLK       (CLK),
        .RSTn      (RSTn),
        .imem_addr (imem_addr),
        .imem_en   (imem_en),
        .imem_data (imem_data),
        .retire    (retire),
        .num_inst  (num_inst),
        .halt      (halt)
    );

    assign imem_data = imem[imem_addr[IMEM_AW-1:2]];  // Word lookup, same cycle

    always #2 CLK = ~CLK;

    // Watchdog over all programs
    always @(posedge CLK) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: halt not reached within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////
    function logic [31:0] lfsr_take(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                input logic [4:0] rs1, input logic [2:0] f3,
                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                input logic [2:0] f3, input logic [4:0] rd,
                                input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function logic [31:0] sext12(input logic [11:0] x);
        return {{20{x[11]}}, x};
    endfunction

    task start_program();
        for (int i = 0; i < 1024; i++) begin
            imem[i] = NOP_INSN;
        end
        n_insn = 0;
        exp_q.delete();
        got_q.delete();
    endtask

    task emit(input logic [31:0] insn);
        imem[n_insn] = insn;
        n_insn++;
    endtask

    task expect_wr(input logic [4:0] rd, input logic [31:0] v);
        rf_wr_t w;
        w.we = 1'b1;
        w.wa = rd;
        w.wd = v;
        exp_q.push_back(w);
    endtask

    // LUI then ADDI, rounding the upper part for the signed low half
    task load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [19:0] up;
        up = v[31:12] + {19'b0, v[11]};
        emit({up, rd, OP_LUI});
        expect_wr(rd, {up, 12'b0});
        emit(enc_i(v[11:0], rd, 3'b000, rd, OP_I));
        expect_wr(rd, v);
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    task check_wr(input string name, input rf_wr_t got, input rf_wr_t exp);
        if (got !== exp) begin
            $display("error %s: got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s: got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task run_program(input string name, input int exp_num);
        cycle_limit += 60 * n_insn;
        @(posedge CLK);
        RSTn <= 1'b1;
        repeat (16) @(posedge CLK);
        RSTn <= 1'b0;
        @(negedge CLK);
        check_bit({name, " imem_en"}, imem_en, 1'b1);
        check_bit({name, " halt"}, halt, 1'b0);
        check_word({name, " num_inst"}, num_inst, 32'd0);
        forever begin
            if (retire.we) begin
                got_q.push_back(retire);
            end
            if (halt) break;
            @(negedge CLK);
        end
        repeat (8) begin
            @(negedge CLK);
            if (retire.we) begin
                $display("%s: register write seen after halt", name);
                errors++;
            end
            if (!halt) begin
                $display("%s: halt dropped before reset", name);
                errors++;
            end
            check_bit({name, " imem_en"}, imem_en, 1'b0);  // Fetch stays off
        end
        if (got_q.size() != exp_q.size()) begin
            $display("%s: %0d retire writes seen, %0d expected", name,
                     got_q.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_wr({name, " retire"}, got_q[i], exp_q[i]);
        end
        check_word({name, " num_inst"}, num_inst, exp_num);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [11:0] imm;
        start_program();
        a   = lfsr_take(32);
        b   = lfsr_take(32);
        r   = lfsr_take(12);
        imm = r[11:0];
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        expect_wr(5'd3, a + b);
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        expect_wr(5'd4, a - b);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        expect_wr(5'd5, a & b);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        expect_wr(5'd6, a | b);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        expect_wr(5'd7, a ^ b);
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));
        expect_wr(5'd8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        emit(enc_i(imm, 5'd1, 3'b111, 5'd9, OP_I));
        expect_wr(5'd9, a & sext12(imm));
        emit(enc_i(imm, 5'd1, 3'b110, 5'd10, OP_I));
        expect_wr(5'd10, a | sext12(imm));
        emit(enc_i(imm, 5'd1, 3'b100, 5'd11, OP_I));
        expect_wr(5'd11, a ^ sext12(imm));
        emit(enc_i(imm, 5'd2, 3'b000, 5'd12, OP_I));
        expect_wr(5'd12, b + sext12(imm));
        emit(enc_i(12'd5, 5'd1, 3'b000, 5'd0, OP_I));  // Write to x0 never retires
        emit(EBREAK_INSN);
        run_program("alu", n_insn);
    endtask

    task test_forward();
        logic [31:0] r;
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x3;
        logic [31:0] x4;
        start_program();
        r  = lfsr_take(12);
        x1 = sext12(r[11:0]);
        x2 = x1 + x1;
        x3 = x2 + x1;
        x4 = x3 - x1;
        emit(enc_i(r[11:0], 5'd0, 3'b000, 5'd1, OP_I));
        expect_wr(5'd1, x1);
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
        expect_wr(5'd2, x2);
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
        expect_wr(5'd3, x3);
        emit(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        expect_wr(5'd4, x4);
        emit(enc_r(7'h00, 5'd2, 5'd4, 3'b100, 5'd5));
        expect_wr(5'd5, x4 ^ x2);
        emit(enc_r(7'h00, 5'd3, 5'd5, 3'b110, 5'd6));
        expect_wr(5'd6, (x4 ^ x2) | x3);
        emit(EBREAK_INSN);
        run_program("forward", n_insn);
    endtask

    task test_mem();
        logic [31:0] v1;
        logic [31:0] v2;
        start_program();
        v1 = lfsr_take(32);
        v2 = lfsr_take(32);
        load_const(5'd2, v1);
        load_const(5'd3, v2);
        emit(enc_i(12'd100, 5'd0, 3'b000, 5'd1, OP_I));
        expect_wr(5'd1, 32'd100);
        emit(enc_s(12'd0, 5'd2, 5'd1));
        emit(enc_s(12'd4, 5'd3, 5'd1));
        emit(enc_i(12'd0, 5'd1, 3'b010, 5'd4, OP_LOAD));
        expect_wr(5'd4, v1);
        emit(enc_r(7'h00, 5'd3, 5'd4, 3'b000, 5'd5));
        expect_wr(5'd5, v1 + v2);
        emit(enc_i(12'd4, 5'd1, 3'b010, 5'd6, OP_LOAD));
        expect_wr(5'd6, v2);
        emit(enc_r(7'h20, 5'd4, 5'd6, 3'b000, 5'd7));
        expect_wr(5'd7, v2 - v1);
        emit(EBREAK_INSN);
        run_program("mem", n_insn);
    endtask

    task test_branch();
        start_program();
        emit(enc_i(12'd3, 5'd0, 3'b000, 5'd1, OP_I));
        expect_wr(5'd1, 32'd3);
        emit(enc_i(12'd3, 5'd0, 3'b000, 5'd2, OP_I));
        expect_wr(5'd2, 32'd3);
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b000));        // BEQ taken to 16
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd3, OP_I));  // Skipped
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b001));        // BNE not taken
        emit(enc_i(12'd2, 5'd0, 3'b000, 5'd4, OP_I));
        expect_wr(5'd4, 32'd2);
        emit(enc_j(21'd8, 5'd5));
        expect_wr(5'd5, 32'd28);
        emit(enc_i(12'd9, 5'd0, 3'b000, 5'd6, OP_I));  // Skipped
        emit(enc_i(12'd4, 5'd0, 3'b000, 5'd7, OP_I));
        expect_wr(5'd7, 32'd4);
        emit(enc_b(13'd8, 5'd7, 5'd1, 3'b000));        // BEQ not taken
        emit(enc_b(13'd8, 5'd7, 5'd1, 3'b001));        // BNE taken to 48
        emit(enc_i(12'd1, 5'd0, 3'b000, 5'd8, OP_I));  // Skipped
        emit(EBREAK_INSN);
        run_program("branch", 10);
    endtask

    task test_halt();
        start_program();
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_I));
        expect_wr(5'd1, 32'd5);
        emit(enc_i(12'd1, 5'd1, 3'b000, 5'd2, OP_I));
        expect_wr(5'd2, 32'd6);
        emit(EBREAK_INSN);
        emit(enc_i(12'd7, 5'd0, 3'b000, 5'd3, OP_I));  // Past the halt
        emit(enc_s(12'd0, 5'd2, 5'd0));
        emit(enc_i(12'd8, 5'd0, 3'b000, 5'd4, OP_I));
        run_program("halt", 3);
    endtask

    initial begin
        CLK         = 1'b0;
        RSTn       <= 1'b1;
        lfsr_state  = 32'h7a99;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 0;
        test_alu();
        test_forward();
        test_mem();
        test_branch();
        test_halt();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
common/riscv_pkg.sv
core/alu.sv
core/decode_ctrl.sv
core/hazard_unit.sv
core/riscv_top.sv
verilog/reg_file.sv
verilog/data_ram.sv
verilog/riscv_soc.sv
tests/tb_riscv.sv

// File: verilog/data_ram.sv
`timescale 1ns/100ps

module data_ram import riscv_pkg::*; (
    input  logic            CLK,
    input  dmem_req_t       req,
    output logic [XLEN-1:0] rdata
);

    localparam int DEPTH = 2**DMEM_AW;  // 1024 words

    logic [XLEN-1:0] mem [0:DEPTH-1];

    // Read is combinational, answers in the memory stage
    assign rdata = mem[req.addr];

    always_ff @(posedge CLK) begin
        if (req.we) begin
            mem[req.addr] <= req.wdata;
        end
    end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/100ps

module reg_file import riscv_pkg::*; (
    input  logic            CLK,
    input  logic            RSTn,
    input  rf_rd_t          rf_rd,
    input  rf_wr_t          rf_wr,
    output logic [XLEN-1:0] rd1,
    output logic [XLEN-1:0] rd2
);

    logic [XLEN-1:0] regs [0:31];

    // Write-through so decode sees this cycle's writeback
    function automatic logic [XLEN-1:0] rd_port(input logic [4:0]      ra,
                                                input rf_wr_t          wr,
                                                input logic [XLEN-1:0] stored);
        if (ra == 5'd0) begin
            return '0;
        end else if (wr.we && wr.wa == ra) begin
            return wr.wd;
        end
        return stored;
    endfunction

    assign rd1 = rd_port(rf_rd.ra1, rf_wr, regs[rf_rd.ra1]);
    assign rd2 = rd_port(rf_rd.ra2, rf_wr, regs[rf_rd.ra2]);

    always_ff @(posedge CLK) begin
        if (RSTn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wr.we && rf_wr.wa != 5'd0) begin
            regs[rf_wr.wa] <= rf_wr.wd;
        end
    end

endmodule

// File: verilog/riscv_soc.sv
`timescale 1ns/100ps

module riscv_soc import riscv_pkg::*; (
    input  logic               CLK,
    input  logic               RSTn,
    output logic [IMEM_AW-1:0] imem_addr,
    output logic               imem_en,
    input  logic [31:0]        imem_data,
    output rf_wr_t             retire,
    output logic [31:0]        num_inst,
    output logic               halt
);

    rf_rd_t          rf_rd;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    dmem_req_t       dmem_req;
    logic [XLEN-1:0] dmem_rdata;

    riscv_top i_riscv_top (
        .CLK        (CLK),
        .RSTn       (RSTn),
        .imem_addr  (imem_addr),
        .imem_en    (imem_en),
        .imem_data  (imem_data),
        .rf_rd      (rf_rd),
        .rd1        (rd1),
        .rd2        (rd2),
        .rf_wr      (retire),  // Register write doubles as the retire port
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .num_inst   (num_inst),
        .halt       (halt)
    );

    reg_file i_reg_file (
        .CLK   (CLK),
        .RSTn  (RSTn),
        .rf_rd (rf_rd),
        .rf_wr (retire),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    data_ram i_data_ram (
        .CLK   (CLK),
        .req   (dmem_req),
        .rdata (dmem_rdata)
    );

endmodule
